// File: logic/wb_pkg.sv
package wb_pkg;

    // writeback source of one lane
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_ALU  = 3'd1,
        OP_LINK = 3'd2,
        OP_DIV  = 3'd3,
        OP_MOD  = 3'd4,
        OP_CSR  = 3'd5,
        OP_LOAD = 3'd6
    } wb_op_e;

    // one execute-stage lane entering writeback
    typedef struct packed {
        wb_op_e      op;
        logic [4:0]  rd;
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] result;
    } lane_in_t;

    // single register file write port
    typedef struct packed {
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
    } rf_write_t;

    // debug trace of one retired lane
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
        logic        we;
        logic [4:0]  rd;
        logic [31:0] wdata;
    } trace_t;

endpackage

// File: logic/exc_pkg.sv
package exc_pkg;

    // loongarch exception codes
    typedef enum logic [6:0] {
        INT  = 7'h00,
        PIL  = 7'h01,
        PIS  = 7'h02,
        PIF  = 7'h03,
        PME  = 7'h04,
        PPI  = 7'h07,
        ADEF = 7'h08,
        ALE  = 7'h09,
        SYS  = 7'h0b,
        BRK  = 7'h0c,
        INE  = 7'h0d,
        TLBR = 7'h3f
    } exc_code_e;

    // exception travelling with lane 0
    typedef struct packed {
        logic        valid;
        exc_code_e   ecode;
        logic [31:0] badv;
        logic [31:0] era;
    } exc_req_t;

    typedef struct packed {
        logic        exc_valid;
        exc_code_e   ecode;
        logic        tlb_refill;
        logic [31:0] badv;
        logic        wen_badv;
        logic [31:0] era;
        logic        wen_era;
        logic [18:0] vppn;
        logic        wen_vppn;
    } csr_update_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } redirect_t;

endpackage

// File: logic/wb_result_select.sv
`timescale 1ns/10ps

module wb_result_select
    import wb_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            aresetn,
    input  lane_in_t        lane0,
    input  lane_in_t        lane1,
    input  logic [XLEN-1:0] quotient,
    input  logic [XLEN-1:0] remainder,
    input  logic [XLEN-1:0] csr_rdata,
    input  logic [XLEN-1:0] load_data,
    input  logic            div_ready,
    input  logic            csr_ready,
    input  logic            dcache_ready,
    input  logic [4:0]      load_rd,
    output logic            allowin,
    output rf_write_t       wr0,
    output rf_write_t       wr1,
    output rf_write_t       wr2
);

    logic      load_pending;
    logic      load_issue;
    logic      lane0_stall;
    logic      lane1_stall;
    rf_write_t wr0_d;
    rf_write_t wr1_d;
    rf_write_t wr2_d;

    // source mux plus ready condition for one lane
    function automatic rf_write_t lane_write(input lane_in_t l, input logic csr_ok);
        rf_write_t w;
        w.rd   = l.rd;
        w.data = l.result;
        w.we   = 1'b0;
        case (l.op)
            OP_ALU: begin
                w.we = 1'b1;
            end
            OP_LINK: begin
                w.data = l.result + 32'd4;
                w.we   = 1'b1;
            end
            OP_DIV: begin
                w.data = quotient;
                w.we   = div_ready;
            end
            OP_MOD: begin
                w.data = remainder;
                w.we   = div_ready;
            end
            OP_CSR: begin
                // csr port only sits on lane 0
                w.data = csr_rdata;
                w.we   = csr_ok && csr_ready;
            end
            default: begin
                w.we = 1'b0;
            end
        endcase
        if (l.rd == 5'd0) begin
            w.we = 1'b0;
        end
        return w;
    endfunction

    assign lane0_stall = ((lane0.op == OP_DIV || lane0.op == OP_MOD) && !div_ready)
                      || (lane0.op == OP_CSR && !csr_ready)
                      || (lane0.op == OP_LOAD && load_pending && !dcache_ready);
    assign lane1_stall = (lane1.op == OP_DIV || lane1.op == OP_MOD) && !div_ready;

    assign allowin    = !(lane0_stall || lane1_stall);
    assign load_issue = (lane0.op == OP_LOAD) && allowin;

    always_comb begin
        wr0_d = lane_write(lane0, 1'b1);
        wr1_d = lane_write(lane1, 1'b0);
        // both lanes retire together, so a held pair writes once
        wr0_d.we = wr0_d.we && allowin;
        wr1_d.we = wr1_d.we && allowin;
        wr2_d.we   = dcache_ready && load_pending && (load_rd != 5'd0);
        wr2_d.rd   = load_rd;
        wr2_d.data = load_data;
    end

    // one load outstanding at a time
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            load_pending <= 1'b0;
        end else if (load_issue) begin
            load_pending <= 1'b1;
        end else if (dcache_ready) begin
            load_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            wr0 <= '0;
            wr1 <= '0;
            wr2 <= '0;
        end else begin
            wr0 <= wr0_d;
            wr1 <= wr1_d;
            wr2 <= wr2_d;
        end
    end

endmodule

// File: logic/wb_exception_unit.sv
`timescale 1ns/10ps

module wb_exception_unit
    import wb_pkg::*;
    import exc_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            aresetn,
    input  exc_req_t        exc_in,
    input  logic            cpu_interrupt,
    input  lane_in_t        lane0,
    input  logic            csr_ready,
    input  logic [XLEN-1:0] eentry,
    input  logic [XLEN-1:0] tlbrentry,
    output csr_update_t     csr_upd,
    output redirect_t       redirect
);

    logic        exc_take;
    logic        set_badv;
    logic        set_vppn;
    logic        refill;
    csr_update_t upd_d;
    redirect_t   redir_d;

    assign exc_take = exc_in.valid || cpu_interrupt;

    // address faults carry a bad virtual address
    assign set_badv = exc_in.ecode inside {PIL, PIS, PIF, PME, PPI, ADEF, ALE, TLBR};
    // only tlb faults also load vppn
    assign set_vppn = exc_in.ecode inside {PIL, PIS, PIF, PME, PPI, TLBR};
    assign refill   = exc_in.valid && (exc_in.ecode == TLBR);

    always_comb begin
        upd_d.exc_valid  = exc_take;
        upd_d.ecode      = exc_in.valid ? exc_in.ecode : INT;
        upd_d.tlb_refill = refill;
        upd_d.badv       = exc_in.badv;
        upd_d.wen_badv   = exc_in.valid && set_badv;
        upd_d.era        = exc_in.era;
        upd_d.wen_era    = exc_take;
        upd_d.vppn       = exc_in.badv[18:0];
        upd_d.wen_vppn   = exc_in.valid && set_vppn;
    end

    // exception first, then refetch after a csr op
    always_comb begin
        redir_d.valid = 1'b0;
        redir_d.pc    = lane0.pc + 32'd4;
        if (exc_take) begin
            redir_d.valid = 1'b1;
            redir_d.pc    = refill ? tlbrentry : eentry;
        end else if (lane0.op == OP_CSR && csr_ready) begin
            redir_d.valid = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            csr_upd  <= '0;
            redirect <= '0;
        end else begin
            csr_upd  <= upd_d;
            redirect <= redir_d;
        end
    end

endmodule

// File: logic/wb_commit.sv
`timescale 1ns/10ps

module wb_commit
    import wb_pkg::*;
    import exc_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            aresetn,
    input  rf_write_t       wr0,
    input  rf_write_t       wr1,
    input  rf_write_t       wr2,
    input  csr_update_t     csr_upd,
    input  logic            allowin,
    input  lane_in_t        lane0,
    input  lane_in_t        lane1,
    input  logic [4:0]      raddr0,
    input  logic [4:0]      raddr1,
    output logic [XLEN-1:0] rdata0,
    output logic [XLEN-1:0] rdata1,
    output trace_t          trace0,
    output trace_t          trace1,
    output logic            flush
);

    logic [XLEN-1:0] regs [32];
    rf_write_t       wr0_sq;
    rf_write_t       wr1_sq;
    logic            allowin_q;
    logic [31:0]     pc0_q;
    logic [31:0]     pc1_q;
    logic [31:0]     inst0_q;
    logic [31:0]     inst1_q;

    always_comb begin
        wr0_sq = wr0;
        wr1_sq = wr1;
        // excepting lanes never reach the register file
        if (csr_upd.exc_valid) begin
            wr0_sq.we = 1'b0;
            wr1_sq.we = 1'b0;
        end
    end

    // later port wins on a shared rd
    always_ff @(posedge clk) begin
        if (wr0_sq.we) begin
            regs[wr0_sq.rd] <= wr0_sq.data;
        end
        if (wr1_sq.we) begin
            regs[wr1_sq.rd] <= wr1_sq.data;
        end
        if (wr2.we) begin
            regs[wr2.rd] <= wr2.data;
        end
    end

    assign rdata0 = (raddr0 == 5'd0) ? '0 : regs[raddr0];
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];

    // line pc and inst up with the registered writes
    always_ff @(posedge clk) begin
        pc0_q   <= lane0.pc;
        pc1_q   <= lane1.pc;
        inst0_q <= lane0.inst;
        inst1_q <= lane1.inst;
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            allowin_q <= 1'b0;
            trace0    <= '0;
            trace1    <= '0;
        end else begin
            allowin_q <= allowin;
            trace0    <= '{valid: allowin_q, pc: pc0_q, inst: inst0_q,
                           we: wr0_sq.we, rd: wr0_sq.rd, wdata: wr0_sq.data};
            trace1    <= '{valid: allowin_q, pc: pc1_q, inst: inst1_q,
                           we: wr1_sq.we, rd: wr1_sq.rd, wdata: wr1_sq.data};
        end
    end

    assign flush = csr_upd.exc_valid;

endmodule

// File: logic/wb_stage_top.sv
`timescale 1ns/10ps

module wb_stage_top
    import wb_pkg::*;
    import exc_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            aresetn,
    input  lane_in_t        lane0,
    input  lane_in_t        lane1,
    input  exc_req_t        exc_in,
    input  logic            cpu_interrupt,
    input  logic [XLEN-1:0] quotient,
    input  logic [XLEN-1:0] remainder,
    input  logic            div_ready,
    input  logic [XLEN-1:0] csr_rdata,
    input  logic            csr_ready,
    input  logic [XLEN-1:0] load_data,
    input  logic [4:0]      load_rd,
    input  logic            dcache_ready,
    input  logic [XLEN-1:0] eentry,
    input  logic [XLEN-1:0] tlbrentry,
    input  logic [4:0]      raddr0,
    input  logic [4:0]      raddr1,
    output logic            allowin,
    output logic [XLEN-1:0] rdata0,
    output logic [XLEN-1:0] rdata1,
    output csr_update_t     csr_upd,
    output redirect_t       redirect,
    output trace_t          trace0,
    output trace_t          trace1,
    output logic            flush
);

    rf_write_t wr0;
    rf_write_t wr1;
    rf_write_t wr2;

    wb_result_select #(.XLEN(XLEN)) select_i (
        .clk          (clk),
        .aresetn      (aresetn),
        .lane0        (lane0),
        .lane1        (lane1),
        .quotient     (quotient),
        .remainder    (remainder),
        .csr_rdata    (csr_rdata),
        .load_data    (load_data),
        .div_ready    (div_ready),
        .csr_ready    (csr_ready),
        .dcache_ready (dcache_ready),
        .load_rd      (load_rd),
        .allowin      (allowin),
        .wr0          (wr0),
        .wr1          (wr1),
        .wr2          (wr2)
    );

    wb_exception_unit #(.XLEN(XLEN)) exc_i (
        .clk           (clk),
        .aresetn       (aresetn),
        .exc_in        (exc_in),
        .cpu_interrupt (cpu_interrupt),
        .lane0         (lane0),
        .csr_ready     (csr_ready),
        .eentry        (eentry),
        .tlbrentry     (tlbrentry),
        .csr_upd       (csr_upd),
        .redirect      (redirect)
    );

    wb_commit #(.XLEN(XLEN)) commit_i (
        .clk     (clk),
        .aresetn (aresetn),
        .wr0     (wr0),
        .wr1     (wr1),
        .wr2     (wr2),
        .csr_upd (csr_upd),
        .allowin (allowin),
        .lane0   (lane0),
        .lane1   (lane1),
        .raddr0  (raddr0),
        .raddr1  (raddr1),
        .rdata0  (rdata0),
        .rdata1  (rdata1),
        .trace0  (trace0),
        .trace1  (trace1),
        .flush   (flush)
    );

endmodule

// File: tb/wb_model.svh
`ifndef WB_MODEL_SVH
`define WB_MODEL_SVH

// reference register file
logic [31:0] mrf [32];
// set once an entry has been written
logic        known [32];

function automatic logic allowin_rule(input lane_in_t l0, input lane_in_t l1,
                                      input logic div_rdy, input logic csr_rdy,
                                      input logic dc_rdy, input logic pend);
    logic stall;
    stall = 1'b0;
    if ((l0.op == OP_DIV || l0.op == OP_MOD) && !div_rdy) stall = 1'b1;
    if ((l1.op == OP_DIV || l1.op == OP_MOD) && !div_rdy) stall = 1'b1;
    if (l0.op == OP_CSR && !csr_rdy) stall = 1'b1;
    if (l0.op == OP_LOAD && pend && !dc_rdy) stall = 1'b1;
    return !stall;
endfunction

// expected write of one lane before squash
function automatic rf_write_t lane_write_ref(input lane_in_t l, input logic has_csr,
                                             input logic [31:0] quo, input logic [31:0] rem,
                                             input logic [31:0] csr_data,
                                             input logic div_rdy, input logic csr_rdy,
                                             input logic allow);
    rf_write_t w;
    w.rd   = l.rd;
    w.we   = 1'b0;
    w.data = 32'd0;
    if (l.op == OP_ALU) begin
        w.we   = 1'b1;
        w.data = l.result;
    end else if (l.op == OP_LINK) begin
        w.we   = 1'b1;
        w.data = l.result + 32'd4;
    end else if (l.op == OP_DIV) begin
        w.we   = div_rdy;
        w.data = quo;
    end else if (l.op == OP_MOD) begin
        w.we   = div_rdy;
        w.data = rem;
    end else if (l.op == OP_CSR && has_csr) begin
        w.we   = csr_rdy;
        w.data = csr_data;
    end
    w.we = w.we && allow && (l.rd != 5'd0);
    return w;
endfunction

function automatic csr_update_t csr_update_ref(input exc_req_t e, input logic intr);
    csr_update_t u;
    logic addr_fault;
    logic tlb_fault;
    addr_fault = (e.ecode == PIL || e.ecode == PIS || e.ecode == PIF || e.ecode == PME
                  || e.ecode == PPI || e.ecode == ADEF || e.ecode == ALE || e.ecode == TLBR);
    tlb_fault  = (e.ecode == PIL || e.ecode == PIS || e.ecode == PIF || e.ecode == PME
                  || e.ecode == PPI || e.ecode == TLBR);
    u.exc_valid  = e.valid || intr;
    u.ecode      = e.valid ? e.ecode : INT;
    u.tlb_refill = e.valid && e.ecode == TLBR;
    u.badv       = e.badv;
    u.wen_badv   = e.valid && addr_fault;
    u.era        = e.era;
    u.wen_era    = e.valid || intr;
    u.vppn       = e.badv[18:0];
    u.wen_vppn   = e.valid && tlb_fault;
    return u;
endfunction

function automatic redirect_t redirect_ref(input exc_req_t e, input logic intr,
                                           input lane_in_t l0, input logic csr_rdy,
                                           input logic [31:0] eent, input logic [31:0] tlbr);
    redirect_t r;
    r.valid = 1'b0;
    r.pc    = l0.pc + 32'd4;
    if (e.valid || intr) begin
        r.valid = 1'b1;
        r.pc    = (e.valid && e.ecode == TLBR) ? tlbr : eent;
    end else if (l0.op == OP_CSR && csr_rdy) begin
        r.valid = 1'b1;
    end
    return r;
endfunction

task automatic rf_apply(input rf_write_t w);
    if (w.we && w.rd != 5'd0) begin
        mrf[w.rd]   = w.data;
        known[w.rd] = 1'b1;
    end
endtask

`endif

// File: tb/wb_stage_tb.sv
`timescale 1ns/10ps

module wb_stage_tb
    import wb_pkg::*;
    import exc_pkg::*;
;
    localparam int XLEN   = 32;
    localparam int NRAND  = 2000;
    localparam int TOTAL  = NRAND + 6;

    logic clk = 1'b0;
    logic aresetn;
    lane_in_t lane0, lane1;
    exc_req_t exc_in;
    logic cpu_interrupt, div_ready, csr_ready, dcache_ready;
    logic [XLEN-1:0] quotient, remainder, csr_rdata, load_data, eentry, tlbrentry;
    logic [4:0] load_rd, raddr0, raddr1;
    logic allowin, flush;
    logic [XLEN-1:0] rdata0, rdata1;
    csr_update_t csr_upd;
    redirect_t redirect;
    trace_t trace0, trace1;

    integer seed = 32'hdc57bbe5;

    `include "wb_model.svh"

    csr_update_t eupd [TOTAL];
    redirect_t   erdr [TOTAL];
    rf_write_t   ew0 [TOTAL];
    rf_write_t   ew1 [TOTAL];
    rf_write_t   ew2 [TOTAL];
    logic        evalid [TOTAL];
    lane_in_t    elane0 [TOTAL];
    lane_in_t    elane1 [TOTAL];

    wb_stage_top #(.XLEN(XLEN)) dut_i (.*);

    always #2 clk = !clk;

    initial begin
        #((TOTAL + 32 + 4 + 50) * 4);
        $display("watchdog: simulation did not finish in time");
        $display("Errors found");
        $fatal(1);
    end

    task automatic check_write(input string name, input rf_write_t exp, input rf_write_t act);
        if (exp !== act) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic check_csr(input string name, input csr_update_t exp, input csr_update_t act);
        if (exp !== act) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic check_redirect(input string name, input redirect_t exp, input redirect_t act);
        if (exp !== act) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic check_data(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (exp !== act) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // trace fields only matter when the write is enabled
    function automatic rf_write_t trace_write(input trace_t t);
        rf_write_t w;
        w.we   = t.we;
        w.rd   = t.we ? t.rd : 5'd0;
        w.data = t.we ? t.wdata : 32'd0;
        return w;
    endfunction

    function automatic rf_write_t masked(input rf_write_t w);
        rf_write_t m;
        m.we   = w.we;
        m.rd   = w.we ? w.rd : 5'd0;
        m.data = w.we ? w.data : 32'd0;
        return m;
    endfunction

    function automatic lane_in_t random_lane(input logic is_lane0, input logic no_div);
        lane_in_t l;
        int sel;
        sel = $unsigned($random(seed)) % (is_lane0 ? 7 : 5);
        if (!is_lane0 && sel == 4) sel = 3;
        if (no_div && (sel == 3 || sel == 4)) sel = 1;
        case (sel)
            0: l.op = OP_NONE;
            1: l.op = OP_ALU;
            2: l.op = OP_LINK;
            3: l.op = is_lane0 ? OP_DIV : (($random(seed) & 1) ? OP_DIV : OP_MOD);
            4: l.op = OP_MOD;
            5: l.op = OP_CSR;
            default: l.op = OP_LOAD;
        endcase
        // small rd range gives port collisions
        l.rd     = ($random(seed) & 1) ? 5'($random(seed) & 7) : 5'($random(seed));
        l.pc     = $random(seed) & 32'hffff_fffc;
        l.inst   = $random(seed);
        l.result = $random(seed);
        return l;
    endfunction

    function automatic exc_code_e random_code();
        case ($unsigned($random(seed)) % 12)
            0: return INT;
            1: return PIL;
            2: return PIS;
            3: return PIF;
            4: return PME;
            5: return PPI;
            6: return ADEF;
            7: return ALE;
            8: return SYS;
            9: return BRK;
            10: return INE;
            default: return TLBR;
        endcase
    endfunction

    task automatic drive_idle();
        lane0 = '0;
        lane1 = '0;
        exc_in = '{valid: 1'b0, ecode: INT, badv: 32'd0, era: 32'd0};
        cpu_interrupt = 1'b0;
        div_ready = 1'b0;
        csr_ready = 1'b0;
        dcache_ready = 1'b0;
    endtask

    task automatic check_reset_state();
        check_data("reset allowin", 1, allowin);
        check_data("reset flush", 0, flush);
        check_data("reset csr enables", 0,
                   {csr_upd.exc_valid, csr_upd.wen_badv, csr_upd.wen_era, csr_upd.wen_vppn});
        check_data("reset redirect valid", 0, redirect.valid);
        check_data("reset trace", 0, {trace0.valid, trace0.we, trace1.valid, trace1.we});
    endtask

    initial begin
        logic pend;
        logic allow;
        logic hold;
        logic no_div;
        rf_write_t w0, w1, w2;
        aresetn = 1'b0;
        drive_idle();
        quotient = 0;
        remainder = 0;
        csr_rdata = 0;
        load_data = 0;
        load_rd = 0;
        eentry = 32'h1c00_8000;
        tlbrentry = 32'h1c00_f000;
        raddr0 = 0;
        raddr1 = 0;
        for (int i = 0; i < 32; i++) known[i] = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_reset_state();
        end
        aresetn = 1'b1;
        @(negedge clk);
        check_reset_state();
        pend = 1'b0;
        allow = 1'b1;
        for (int k = 0; k < TOTAL; k++) begin
            @(negedge clk);
            if (k >= 1) begin
                check_csr("csr update", eupd[k-1], csr_upd);
                check_redirect("redirect", erdr[k-1], redirect);
                check_data("flush", eupd[k-1].exc_valid, flush);
            end
            if (k >= 2) begin
                rf_apply(ew0[k-2]);
                rf_apply(ew1[k-2]);
                rf_apply(ew2[k-2]);
                check_data("trace0 valid", evalid[k-2], trace0.valid);
                check_data("trace1 valid", evalid[k-2], trace1.valid);
                check_data("trace0 pc", elane0[k-2].pc, trace0.pc);
                check_data("trace0 inst", elane0[k-2].inst, trace0.inst);
                check_data("trace1 pc", elane1[k-2].pc, trace1.pc);
                check_data("trace1 inst", elane1[k-2].inst, trace1.inst);
                check_write("trace0 write", masked(ew0[k-2]), trace_write(trace0));
                check_write("trace1 write", masked(ew1[k-2]), trace_write(trace1));
            end
            if (k >= 1 && (raddr0 == 0 || known[raddr0]))
                check_data("rdata0", raddr0 == 0 ? 32'd0 : mrf[raddr0], rdata0);
            if (k >= 1 && (raddr1 == 0 || known[raddr1]))
                check_data("rdata1", raddr1 == 0 ? 32'd0 : mrf[raddr1], rdata1);
            hold = !allow;
            if (k >= NRAND) begin
                drive_idle();
            end else begin
                if (!hold) begin
                    lane0 = random_lane(1'b1, 1'b0);
                    no_div = (lane0.op == OP_DIV || lane0.op == OP_MOD);
                    lane1 = random_lane(1'b0, no_div);
                end
                exc_in.valid = ($random(seed) & 7) == 0;
                exc_in.ecode = random_code();
                exc_in.badv = $random(seed);
                exc_in.era = $random(seed);
                cpu_interrupt = ($random(seed) & 15) == 0;
                div_ready = ($random(seed) & 3) == 0;
                csr_ready = ($random(seed) & 1) != 0;
                dcache_ready = ($random(seed) & 3) == 0;
            end
            quotient = $random(seed);
            remainder = $random(seed);
            csr_rdata = $random(seed);
            load_data = $random(seed);
            load_rd = 5'($random(seed) & 7);
            raddr0 = 5'($random(seed));
            raddr1 = 5'($random(seed) & 7);
            #1;
            allow = allowin_rule(lane0, lane1, div_ready, csr_ready, dcache_ready, pend);
            check_data("allowin", allow, allowin);
            eupd[k] = csr_update_ref(exc_in, cpu_interrupt);
            erdr[k] = redirect_ref(exc_in, cpu_interrupt, lane0, csr_ready, eentry, tlbrentry);
            w0 = lane_write_ref(lane0, 1'b1, quotient, remainder, csr_rdata, div_ready,
                                csr_ready, allow);
            w1 = lane_write_ref(lane1, 1'b0, quotient, remainder, csr_rdata, div_ready,
                                csr_ready, allow);
            // the exception squashes lane writes but not the load port
            if (eupd[k].exc_valid) begin
                w0.we = 1'b0;
                w1.we = 1'b0;
            end
            w2.we = dcache_ready && pend && load_rd != 5'd0;
            w2.rd = load_rd;
            w2.data = load_data;
            ew0[k] = w0;
            ew1[k] = w1;
            ew2[k] = w2;
            evalid[k] = allow;
            elane0[k] = lane0;
            elane1[k] = lane1;
            if (lane0.op == OP_LOAD && allow) pend = 1'b1;
            else if (dcache_ready) pend = 1'b0;
        end
        // sweep the register file
        for (int r = 0; r < 32; r++) begin
            @(negedge clk);
            raddr0 = 5'(r);
            raddr1 = 5'(31 - r);
            #1;
            if (r == 0 || known[r]) check_data("sweep rdata0", r == 0 ? 32'd0 : mrf[r], rdata0);
            if (r == 31 || known[31-r])
                check_data("sweep rdata1", r == 31 ? 32'd0 : mrf[31-r], rdata1);
        end
        $display("No errors");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+tb
logic/wb_pkg.sv
logic/exc_pkg.sv
logic/wb_result_select.sv
logic/wb_exception_unit.sv
logic/wb_commit.sv
logic/wb_stage_top.sv
tb/wb_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the writeback stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f --top-module wb_stage_tb \
    -o wb_stage_tb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/wb_stage_tb_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^No errors$"; then
    exit 0
fi
echo "pass message not found"
exit 1
